// ==== common/vtx_pkg.sv ====
package vtx_pkg;

	// ------------------------------------------------------------
	// FIFO word, header view and pixel view
	// ------------------------------------------------------------
	typedef struct packed {
		logic [15:0] line_num;
		logic [15:0] rsvd;
	} line_hdr_t;

	typedef struct packed {
		logic [7:0] y0;
		logic [7:0] c0;
		logic [7:0] y1;
		logic [7:0] c1;
	} pix_pair_t;

	// First word of a line is a header, the rest are pixel pairs
	typedef union packed {
		line_hdr_t hdr;
		pix_pair_t pix;
	} fifo_word_u;

	typedef struct packed {
		logic [7:0]  y;
		logic [7:0]  c;
		logic        sol;
		logic [15:0] line_num;
	} pixel_t;

	typedef struct packed {
		logic [47:0] dst_mac;
		logic [47:0] src_mac;
		logic [31:0] src_ip;
		logic [31:0] dst_ip;
		logic [15:0] src_port;
		logic [15:0] dst_port;
		logic        enable;
	} net_cfg_t;

	// ------------------------------------------------------------
	// AXI4-Lite channels
	// ------------------------------------------------------------
	typedef struct packed {
		logic [7:0]  awaddr;
		logic        awvalid;
		logic [31:0] wdata;
		logic [3:0]  wstrb;
		logic        wvalid;
		logic        bready;
		logic [7:0]  araddr;
		logic        arvalid;
		logic        rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		logic        bvalid;
		logic [1:0]  bresp;
		logic        arready;
		logic        rvalid;
		logic [31:0] rdata;
		logic [1:0]  rresp;
	} axil_rsp_t;

	// Register map
	localparam logic [7:0] REG_DST_MAC_HI = 8'h00;
	localparam logic [7:0] REG_DST_MAC_LO = 8'h04;
	localparam logic [7:0] REG_SRC_MAC_HI = 8'h08;
	localparam logic [7:0] REG_SRC_MAC_LO = 8'h0C;
	localparam logic [7:0] REG_SRC_IP     = 8'h10;
	localparam logic [7:0] REG_DST_IP     = 8'h14;
	localparam logic [7:0] REG_PORTS      = 8'h18;
	localparam logic [7:0] REG_CTRL       = 8'h1C;

	// Ethernet / IPv4 / UDP fields
	localparam logic [15:0] ETH_TYPE_IPV4 = 16'h0800;
	localparam logic [7:0]  IP_VER_IHL    = 8'h45;
	localparam logic [7:0]  IP_TTL        = 8'h40;
	localparam logic [7:0]  IP_PROTO_UDP  = 8'h11;
	localparam logic [15:0] IP_FLAGS      = 16'h4000;
	localparam int          IFG_CYCLES    = 12;

endpackage

// ==== hdl/line_packer.sv ====
`timescale 1ns/1ps

module line_packer #(
	parameter int PIX_PER_LINE = 16
) (
	input  logic                fifo_clk,
	input  logic                sys_rst,
	input  logic                pix_valid,
	output logic                pix_ready,
	input  vtx_pkg::pixel_t     pix,
	output logic                wr_en,
	output vtx_pkg::fifo_word_u wr_word,
	input  logic                full
);

	localparam int CNT_W = $clog2(PIX_PER_LINE + 1);

	logic             pend;
	logic [7:0]       hold_y;
	logic [7:0]       hold_c;
	logic [CNT_W-1:0] pix_cnt;
	logic             xfer;

	// Stall on full, or on a new line while the last pair is still open
	assign pix_ready = !full && !(pend && pix.sol);
	assign xfer      = pix_valid && pix_ready;
	assign wr_en     = xfer && (pix.sol || pend);

	always_comb begin
		if (pix.sol) begin
			wr_word.hdr.line_num = pix.line_num;
			wr_word.hdr.rsvd     = 16'h0000;
		end else begin
			wr_word.pix.y0 = hold_y;
			wr_word.pix.c0 = hold_c;
			wr_word.pix.y1 = pix.y;
			wr_word.pix.c1 = pix.c;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			pend    <= 1'b0;
			pix_cnt <= CNT_W'(PIX_PER_LINE);
		end else if (xfer) begin
			// sol pixel opens a pair, any other pixel toggles it
			pend    <= pix.sol ? 1'b1 : !pend;
			pix_cnt <= pix.sol ? CNT_W'(1) : pix_cnt + 1'b1;
		end
	end

	// Even pixel of a pair
	always_ff @(posedge fifo_clk) begin
		if (xfer && (pix.sol || !pend)) begin
			hold_y <= pix.y;
			hold_c <= pix.c;
		end
	end

	a_whole_line: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(xfer && pix.sol) |-> (pix_cnt == CNT_W'(PIX_PER_LINE)))
		else $error("line_packer: sol before a whole line of pixels");

endmodule

// ==== hdl/pixel_fifo.sv ====
`timescale 1ns/1ps

module pixel_fifo #(
	parameter int FIFO_DEPTH = 32
) (
	input  logic                          fifo_clk,
	input  logic                          sys_rst,
	input  logic                          wr_en,
	input  vtx_pkg::fifo_word_u           wr_word,
	output logic                          full,
	input  logic                          rd_en,
	output vtx_pkg::fifo_word_u           rd_word,
	output logic [$clog2(FIFO_DEPTH):0]   level
);

	localparam int AW = $clog2(FIFO_DEPTH);

	vtx_pkg::fifo_word_u mem [FIFO_DEPTH];
	logic [AW-1:0]       wr_ptr;
	logic [AW-1:0]       rd_ptr;

	assign full    = (level == (AW+1)'(FIFO_DEPTH));
	// Head word is visible before the pop
	assign rd_word = mem[rd_ptr];

	always_ff @(posedge fifo_clk) begin
		if (wr_en) begin
			mem[wr_ptr] <= wr_word;
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			level  <= '0;
		end else begin
			if (wr_en) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (rd_en) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({wr_en, rd_en})
				2'b10:   level <= level + 1'b1;
				2'b01:   level <= level - 1'b1;
				default: level <= level;
			endcase
		end
	end

	a_no_overflow: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		wr_en |-> !full)
		else $error("pixel_fifo: write while full");

	a_no_underflow: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		rd_en |-> (level != '0))
		else $error("pixel_fifo: read while empty");

endmodule

// ==== hdl/net_cfg_regs.sv ====
`timescale 1ns/1ps

module net_cfg_regs (
	input  logic               fifo_clk,
	input  logic               sys_rst,
	input  vtx_pkg::axil_req_t axil_req,
	output vtx_pkg::axil_rsp_t axil_rsp,
	output vtx_pkg::net_cfg_t  cfg
);

	vtx_pkg::net_cfg_t cfg_q;
	logic              wr_rdy;
	logic              wr_fire;
	logic              b_vld;
	logic              rd_rdy;
	logic              rd_fire;
	logic              r_vld;
	logic [31:0]       r_data;
	logic [31:0]       wr_old;
	logic [31:0]       wr_new;

	// Register view of the config; unmapped reads return zero
	function automatic logic [31:0] reg_rd(input logic [7:0] addr,
			input vtx_pkg::net_cfg_t c);
		logic [31:0] v;
		case (addr)
			vtx_pkg::REG_DST_MAC_HI: v = {16'h0000, c.dst_mac[47:32]};
			vtx_pkg::REG_DST_MAC_LO: v = c.dst_mac[31:0];
			vtx_pkg::REG_SRC_MAC_HI: v = {16'h0000, c.src_mac[47:32]};
			vtx_pkg::REG_SRC_MAC_LO: v = c.src_mac[31:0];
			vtx_pkg::REG_SRC_IP:     v = c.src_ip;
			vtx_pkg::REG_DST_IP:     v = c.dst_ip;
			vtx_pkg::REG_PORTS:      v = {c.src_port, c.dst_port};
			vtx_pkg::REG_CTRL:       v = {31'd0, c.enable};
			default:                 v = 32'd0;
		endcase
		return v;
	endfunction

	assign wr_fire = wr_rdy && axil_req.awvalid && axil_req.wvalid;
	assign rd_fire = rd_rdy && axil_req.arvalid;

	// Byte-lane merge onto the current register value
	always_comb begin
		wr_old = reg_rd(axil_req.awaddr, cfg_q);
		for (int i = 0; i < 4; i++) begin
			wr_new[i*8 +: 8] = axil_req.wstrb[i] ? axil_req.wdata[i*8 +: 8] : wr_old[i*8 +: 8];
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			cfg_q  <= '0;
			wr_rdy <= 1'b0;
			b_vld  <= 1'b0;
			rd_rdy <= 1'b0;
			r_vld  <= 1'b0;
		end else begin
			wr_rdy <= axil_req.awvalid && axil_req.wvalid && !wr_rdy && !b_vld;
			rd_rdy <= axil_req.arvalid && !rd_rdy && !r_vld;
			if (wr_fire) begin
				b_vld <= 1'b1;
			end else if (axil_req.bready) begin
				b_vld <= 1'b0;
			end
			if (rd_fire) begin
				r_vld <= 1'b1;
			end else if (axil_req.rready) begin
				r_vld <= 1'b0;
			end
			if (wr_fire) begin
				case (axil_req.awaddr)
					vtx_pkg::REG_DST_MAC_HI: cfg_q.dst_mac[47:32] <= wr_new[15:0];
					vtx_pkg::REG_DST_MAC_LO: cfg_q.dst_mac[31:0]  <= wr_new;
					vtx_pkg::REG_SRC_MAC_HI: cfg_q.src_mac[47:32] <= wr_new[15:0];
					vtx_pkg::REG_SRC_MAC_LO: cfg_q.src_mac[31:0]  <= wr_new;
					vtx_pkg::REG_SRC_IP:     cfg_q.src_ip         <= wr_new;
					vtx_pkg::REG_DST_IP:     cfg_q.dst_ip         <= wr_new;
					vtx_pkg::REG_PORTS: begin
						cfg_q.src_port <= wr_new[31:16];
						cfg_q.dst_port <= wr_new[15:0];
					end
					vtx_pkg::REG_CTRL:       cfg_q.enable         <= wr_new[0];
					default:                 cfg_q                <= cfg_q;
				endcase
			end
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (rd_fire) begin
			r_data <= reg_rd(axil_req.araddr, cfg_q);
		end
	end

	assign cfg              = cfg_q;
	assign axil_rsp.awready = wr_rdy;
	assign axil_rsp.wready  = wr_rdy;
	assign axil_rsp.bvalid  = b_vld;
	assign axil_rsp.bresp   = 2'b00;
	assign axil_rsp.arready = rd_rdy;
	assign axil_rsp.rvalid  = r_vld;
	assign axil_rsp.rdata   = r_data;
	assign axil_rsp.rresp   = 2'b00;

	a_bvalid_hold: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(b_vld && !axil_req.bready) |=> b_vld)
		else $error("net_cfg_regs: bvalid dropped before bready");

endmodule

// ==== gmii_tx/crc32_gen.sv ====
`timescale 1ns/1ps

module crc32_gen (
	input  logic        fifo_clk,
	input  logic        sys_rst,
	input  logic        init,
	input  logic        data_en,
	input  logic [7:0]  data,
	output logic [31:0] crc
);

	// 04C11DB7h in reflected form, LSB first
	localparam logic [31:0] POLY_REFL = 32'hEDB88320;

	logic [31:0] crc_q;
	logic [31:0] crc_nxt;
	logic [31:0] fcs;

	always_comb begin
		crc_nxt = crc_q;
		for (int i = 0; i < 8; i++) begin
			crc_nxt = (crc_nxt >> 1) ^ ((crc_nxt[0] ^ data[i]) ? POLY_REFL : 32'd0);
		end
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			crc_q <= '1;
		end else if (init) begin
			crc_q <= '1;
		end else if (data_en) begin
			crc_q <= crc_nxt;
		end
	end

	// Reflected register already holds the bit-reversed remainder;
	// low byte goes out first, so swap into wire order
	assign fcs = ~crc_q;
	assign crc = {fcs[7:0], fcs[15:8], fcs[23:16], fcs[31:24]};

endmodule

// ==== gmii_tx/frame_builder.sv ====
`timescale 1ns/1ps

module frame_builder #(
	parameter int PIX_PER_LINE = 16,
	parameter int FIFO_DEPTH   = 32
) (
	input  logic                        fifo_clk,
	input  logic                        sys_rst,
	input  vtx_pkg::net_cfg_t           cfg,
	input  logic [$clog2(FIFO_DEPTH):0] level,
	input  vtx_pkg::fifo_word_u         rd_word,
	output logic                        rd_en,
	output logic                        tx_en,
	output logic [7:0]                  txd
);

	localparam int            LW             = $clog2(FIFO_DEPTH) + 1;
	localparam int            WORDS_PER_LINE = 1 + PIX_PER_LINE / 2;
	localparam int            CNT_W          = $clog2(2 * PIX_PER_LINE + 20);
	localparam logic [15:0]   IP_LEN         = 16'(28 + 2 + 2 * PIX_PER_LINE);
	localparam logic [15:0]   UDP_LEN        = 16'(8 + 2 + 2 * PIX_PER_LINE);
	// SFD through last FCS byte
	localparam int            BODY_LEN       = 1 + 42 + 2 + 2 * PIX_PER_LINE + 4;

	typedef enum logic [3:0] {
		S_IDLE, S_PRE, S_SFD, S_ETH, S_IP, S_UDP, S_LNUM, S_PIX, S_FCS, S_GAP
	} tx_state_t;

	tx_state_t        state;
	tx_state_t        nxt_state;
	logic [CNT_W-1:0] cnt;
	logic [CNT_W-1:0] sect_last;
	logic             last;
	logic             start;
	logic             tx_on;
	logic [7:0]       tx_byte;
	logic [41:0][7:0] hdr_sr;
	logic             crc_en;
	logic [31:0]      crc;

	// Ones'-complement sum over the IPv4 header, checksum field as zero
	function automatic logic [15:0] ip_checksum(input vtx_pkg::net_cfg_t c);
		logic [31:0] sum;
		logic [16:0] fold;
		sum = 32'({vtx_pkg::IP_VER_IHL, 8'h00}) + 32'(IP_LEN) + 32'(vtx_pkg::IP_FLAGS)
			+ 32'({vtx_pkg::IP_TTL, vtx_pkg::IP_PROTO_UDP})
			+ 32'(c.src_ip[31:16]) + 32'(c.src_ip[15:0])
			+ 32'(c.dst_ip[31:16]) + 32'(c.dst_ip[15:0]);
		fold = 17'(sum[15:0]) + 17'(sum[31:16]);
		return ~(fold[15:0] + 16'(fold[16]));
	endfunction

	assign start = cfg.enable && (level >= LW'(WORDS_PER_LINE));

	// ------------------------------------------------------------
	// Byte for the next cycle and section bookkeeping
	// ------------------------------------------------------------
	always_comb begin
		tx_on     = 1'b1;
		tx_byte   = 8'h55;
		sect_last = '0;
		nxt_state = state;
		case (state)
			S_IDLE: begin
				tx_on     = start;
				nxt_state = S_PRE;
			end
			S_PRE: begin
				sect_last = CNT_W'(5);
				nxt_state = S_SFD;
			end
			S_SFD: begin
				tx_byte   = 8'hD5;
				nxt_state = S_ETH;
			end
			S_ETH: begin
				tx_byte   = hdr_sr[41];
				sect_last = CNT_W'(13);
				nxt_state = S_IP;
			end
			S_IP: begin
				tx_byte   = hdr_sr[41];
				sect_last = CNT_W'(19);
				nxt_state = S_UDP;
			end
			S_UDP: begin
				tx_byte   = hdr_sr[41];
				sect_last = CNT_W'(7);
				nxt_state = S_LNUM;
			end
			S_LNUM: begin
				tx_byte   = cnt[0] ? rd_word.hdr.line_num[7:0] : rd_word.hdr.line_num[15:8];
				sect_last = CNT_W'(1);
				nxt_state = S_PIX;
			end
			S_PIX: begin
				case (cnt[1:0])
					2'd0:    tx_byte = rd_word.pix.y0;
					2'd1:    tx_byte = rd_word.pix.c0;
					2'd2:    tx_byte = rd_word.pix.y1;
					default: tx_byte = rd_word.pix.c1;
				endcase
				sect_last = CNT_W'(2 * PIX_PER_LINE - 1);
				nxt_state = S_FCS;
			end
			S_FCS: begin
				tx_byte   = crc[31 - 8*cnt[1:0] -: 8];
				sect_last = CNT_W'(3);
				nxt_state = S_GAP;
			end
			default: begin
				tx_on     = 1'b0;
				tx_byte   = 8'h00;
				sect_last = CNT_W'(vtx_pkg::IFG_CYCLES - 1);
				nxt_state = S_IDLE;
			end
		endcase
		last = (state == S_IDLE) ? start : (cnt == sect_last);
	end

	always_ff @(posedge fifo_clk) begin
		if (sys_rst) begin
			state <= S_IDLE;
			cnt   <= '0;
			tx_en <= 1'b0;
			txd   <= 8'h00;
		end else begin
			tx_en <= tx_on;
			txd   <= tx_on ? tx_byte : 8'h00;
			if (last) begin
				state <= nxt_state;
				cnt   <= '0;
			end else if (state != S_IDLE) begin
				cnt   <= cnt + 1'b1;
			end
		end
	end

	// Header bytes, latched from cfg up to the cycle that leaves idle
	always_ff @(posedge fifo_clk) begin
		if (state == S_IDLE) begin
			hdr_sr <= {cfg.dst_mac, cfg.src_mac, vtx_pkg::ETH_TYPE_IPV4,
				vtx_pkg::IP_VER_IHL, 8'h00, IP_LEN, 16'h0000, vtx_pkg::IP_FLAGS,
				vtx_pkg::IP_TTL, vtx_pkg::IP_PROTO_UDP, ip_checksum(cfg),
				cfg.src_ip, cfg.dst_ip,
				cfg.src_port, cfg.dst_port, UDP_LEN, 16'h0000};
		end else if (state == S_ETH || state == S_IP || state == S_UDP) begin
			hdr_sr <= {hdr_sr[40:0], 8'h00};
		end
	end

	// Pop the header after the line number, each pair after its fourth byte
	assign rd_en = (state == S_LNUM && cnt == CNT_W'(1))
		|| (state == S_PIX && cnt[1:0] == 2'd3);

	assign crc_en = (state == S_ETH) || (state == S_IP) || (state == S_UDP)
		|| (state == S_LNUM) || (state == S_PIX);

	crc32_gen crc0 (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.init     (state == S_PRE),
		.data_en  (crc_en),
		.data     (tx_byte),
		.crc      (crc)
	);

	a_tx_en_body: assert property (@(posedge fifo_clk) disable iff (sys_rst)
		(state == S_SFD) |=> tx_en [*BODY_LEN])
		else $error("frame_builder: tx_en dropped inside a frame");

endmodule

// ==== hdl/video_udp_tx_top.sv ====
`timescale 1ns/1ps

module video_udp_tx_top #(
	parameter int PIX_PER_LINE = 16,
	parameter int FIFO_DEPTH   = 32
) (
	input  logic               fifo_clk,
	input  logic               sys_rst,
	input  vtx_pkg::axil_req_t axil_req,
	output vtx_pkg::axil_rsp_t axil_rsp,
	input  logic               pix_valid,
	output logic               pix_ready,
	input  vtx_pkg::pixel_t    pix,
	output logic               gmii_tx_en,
	output logic [7:0]         gmii_txd
);

	logic                        wr_en;
	vtx_pkg::fifo_word_u         wr_word;
	logic                        full;
	logic                        rd_en;
	vtx_pkg::fifo_word_u         rd_word;
	logic [$clog2(FIFO_DEPTH):0] level;
	vtx_pkg::net_cfg_t           cfg;

	// Pixel stream into FIFO words
	line_packer #(.PIX_PER_LINE(PIX_PER_LINE)) packer0 (
		.fifo_clk  (fifo_clk),
		.sys_rst   (sys_rst),
		.pix_valid (pix_valid),
		.pix_ready (pix_ready),
		.pix       (pix),
		.wr_en     (wr_en),
		.wr_word   (wr_word),
		.full      (full)
	);

	pixel_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) fifo0 (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.wr_en    (wr_en),
		.wr_word  (wr_word),
		.full     (full),
		.rd_en    (rd_en),
		.rd_word  (rd_word),
		.level    (level)
	);

	net_cfg_regs regs0 (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.axil_req (axil_req),
		.axil_rsp (axil_rsp),
		.cfg      (cfg)
	);

	// One line per GMII frame
	frame_builder #(.PIX_PER_LINE(PIX_PER_LINE), .FIFO_DEPTH(FIFO_DEPTH)) builder0 (
		.fifo_clk (fifo_clk),
		.sys_rst  (sys_rst),
		.cfg      (cfg),
		.level    (level),
		.rd_word  (rd_word),
		.rd_en    (rd_en),
		.tx_en    (gmii_tx_en),
		.txd      (gmii_txd)
	);

endmodule

// ==== testbench/tb_frame_model.svh ====
`ifndef TB_FRAME_MODEL_SVH
`define TB_FRAME_MODEL_SVH

// ------------------------------------------------------------
// Expected frame, preamble through FCS
// ------------------------------------------------------------
localparam int ETH_OFS  = 8;
localparam int IP_OFS   = 22;
localparam int UDP_OFS  = 42;
localparam int LNUM_OFS = 50;
localparam int PIX_OFS  = 52;
localparam int FCS_OFS  = PIX_OFS + 2 * PPL;

logic [7:0] exp_frame [FRAME_LEN];

function automatic void put16(input int ofs, input logic [15:0] v);
	exp_frame[ofs]     = v[15:8];
	exp_frame[ofs + 1] = v[7:0];
endfunction

function automatic void put32(input int ofs, input logic [31:0] v);
	put16(ofs, v[31:16]);
	put16(ofs + 2, v[15:0]);
endfunction

// Ones'-complement sum of the 20 header bytes, folded until no carry is left
function automatic logic [15:0] ipv4_checksum();
	logic [31:0] acc;
	acc = 32'd0;
	for (int k = 0; k < 20; k += 2) begin
		acc = acc + {16'h0000, exp_frame[IP_OFS + k], exp_frame[IP_OFS + k + 1]};
	end
	while (acc[31:16] != 16'h0000) begin
		acc = {16'h0000, acc[15:0]} + {16'h0000, acc[31:16]};
	end
	return ~acc[15:0];
endfunction

// MSB-first CRC register, each byte fed LSB first as on the wire
function automatic logic [31:0] eth_fcs();
	logic [31:0] r;
	logic [31:0] rev;
	logic        fb;
	r = 32'hFFFF_FFFF;
	for (int k = ETH_OFS; k < FCS_OFS; k++) begin
		for (int b = 0; b < 8; b++) begin
			fb = r[31] ^ exp_frame[k][b];
			r  = {r[30:0], 1'b0};
			if (fb) begin
				r = r ^ 32'h04C1_1DB7;
			end
		end
	end
	for (int b = 0; b < 32; b++) begin
		rev[b] = r[31 - b];
	end
	return ~rev;
endfunction

function automatic void build_frame(input vtx_pkg::net_cfg_t c, input logic [15:0] lnum,
		input logic [2*PPL*8-1:0] px);
	logic [31:0] fcs;
	for (int k = 0; k < 7; k++) begin
		exp_frame[k] = 8'h55;
	end
	exp_frame[7] = 8'hD5;
	put16(ETH_OFS, c.dst_mac[47:32]);
	put32(ETH_OFS + 2, c.dst_mac[31:0]);
	put16(ETH_OFS + 6, c.src_mac[47:32]);
	put32(ETH_OFS + 8, c.src_mac[31:0]);
	put16(ETH_OFS + 12, 16'h0800);
	// IPv4 header, checksum field zero while summing
	put16(IP_OFS, 16'h4500);
	put16(IP_OFS + 2, 16'(20 + 8 + 2 + 2 * PPL));
	put16(IP_OFS + 4, 16'h0000);
	put16(IP_OFS + 6, 16'h4000);
	put16(IP_OFS + 8, 16'h4011);
	put16(IP_OFS + 10, 16'h0000);
	put32(IP_OFS + 12, c.src_ip);
	put32(IP_OFS + 16, c.dst_ip);
	put16(IP_OFS + 10, ipv4_checksum());
	put16(UDP_OFS, c.src_port);
	put16(UDP_OFS + 2, c.dst_port);
	put16(UDP_OFS + 4, 16'(8 + 2 + 2 * PPL));
	put16(UDP_OFS + 6, 16'h0000);
	put16(LNUM_OFS, lnum);
	for (int k = 0; k < 2 * PPL; k++) begin
		exp_frame[PIX_OFS + k] = px[k*8 +: 8];
	end
	// FCS goes out low byte first
	fcs = eth_fcs();
	for (int k = 0; k < 4; k++) begin
		exp_frame[FCS_OFS + k] = fcs[k*8 +: 8];
	end
endfunction

`endif

// ==== testbench/tb_video_udp_tx.sv ====
`timescale 1ns/1ps

module tb_video_udp_tx;

	localparam int PPL             = 16;
	localparam int DEPTH           = 32;
	localparam int FRAME_LEN       = 8 + 42 + 2 + 2 * PPL + 4;
	localparam int IFG             = 12;
	localparam int N_LINES         = 24;
	localparam int WATCHDOG_CYCLES = N_LINES * (FRAME_LEN + IFG + 2 * PPL * 4) + 2000;

	typedef logic [31:0] rdata_t;
	typedef logic [1:0]  resp_t;
	typedef logic [7:0]  txd_t;

	logic               fifo_clk;
	logic               sys_rst;
	vtx_pkg::axil_req_t axil_req;
	vtx_pkg::axil_rsp_t axil_rsp;
	logic               pix_valid;
	logic               pix_ready;
	vtx_pkg::pixel_t    pix;
	logic               gmii_tx_en;
	logic [7:0]         gmii_txd;

	// One word per mapped register address
	logic [31:0]        regs_model [8];
	logic [15:0]        next_lnum;
	int                 lines_pushed;
	int                 frames_seen = 0;

	// Lines still waiting for their frame
	logic [15:0]        exp_lnum [$];
	logic [2*PPL*8-1:0] exp_pix [$];
	vtx_pkg::net_cfg_t  exp_cfg [$];

	logic [7:0]         rx_bytes [FRAME_LEN];
	int                 burst_len = 0;
	int                 idle_cnt = 0;
	logic               prev_en = 1'b0;

	`include "tb_frame_model.svh"

	video_udp_tx_top #(.PIX_PER_LINE(PPL), .FIFO_DEPTH(DEPTH)) dut0 (
		.fifo_clk   (fifo_clk),
		.sys_rst    (sys_rst),
		.axil_req   (axil_req),
		.axil_rsp   (axil_rsp),
		.pix_valid  (pix_valid),
		.pix_ready  (pix_ready),
		.pix        (pix),
		.gmii_tx_en (gmii_tx_en),
		.gmii_txd   (gmii_txd)
	);

	always #4 fifo_clk = ~fifo_clk;

	task automatic fail_run(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_axil_rdata(input string name, input rdata_t got, input rdata_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_axil_resp(input string name, input resp_t got, input resp_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_txd(input string name, input txd_t got, input txd_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	task automatic check_line_num(input string name, input vtx_pkg::line_hdr_t got,
			input vtx_pkg::line_hdr_t exp);
		if (got !== exp) begin
			fail_run($sformatf("** Error: %s got %h expected %h", name, got, exp));
		end
	endtask

	// ------------------------------------------------------------
	// Register model and AXI4-Lite access
	// ------------------------------------------------------------
	function automatic logic [31:0] reg_mask(input int idx);
		case (idx)
			0, 2:    return 32'h0000_FFFF;
			7:       return 32'h0000_0001;
			default: return 32'hFFFF_FFFF;
		endcase
	endfunction

	function automatic vtx_pkg::net_cfg_t model_cfg();
		vtx_pkg::net_cfg_t c;
		c.dst_mac  = {regs_model[0][15:0], regs_model[1]};
		c.src_mac  = {regs_model[2][15:0], regs_model[3]};
		c.src_ip   = regs_model[4];
		c.dst_ip   = regs_model[5];
		c.src_port = regs_model[6][31:16];
		c.dst_port = regs_model[6][15:0];
		c.enable   = regs_model[7][0];
		return c;
	endfunction

	task automatic axil_write(input logic [7:0] addr, input logic [31:0] data,
			input logic [3:0] strb);
		int idx;
		@(posedge fifo_clk);
		#1;
		axil_req.awaddr  = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = strb;
		axil_req.wvalid  = 1'b1;
		axil_req.bready  = 1'b1;
		@(negedge fifo_clk);
		while (!axil_rsp.awready) begin
			@(negedge fifo_clk);
		end
		@(posedge fifo_clk);
		#1;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		@(negedge fifo_clk);
		while (!axil_rsp.bvalid) begin
			@(negedge fifo_clk);
		end
		check_axil_resp("bresp", axil_rsp.bresp, 2'b00);
		@(posedge fifo_clk);
		#1;
		axil_req.bready = 1'b0;
		if (addr[1:0] == 2'b00 && addr < 8'h20) begin
			idx = int'(addr[4:2]);
			for (int i = 0; i < 4; i++) begin
				if (strb[i]) begin
					regs_model[idx][i*8 +: 8] = data[i*8 +: 8];
				end
			end
			regs_model[idx] = regs_model[idx] & reg_mask(idx);
		end
	endtask

	task automatic axil_read(input logic [7:0] addr, output rdata_t data);
		@(posedge fifo_clk);
		#1;
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		axil_req.rready  = 1'b1;
		@(negedge fifo_clk);
		while (!axil_rsp.arready) begin
			@(negedge fifo_clk);
		end
		@(posedge fifo_clk);
		#1;
		axil_req.arvalid = 1'b0;
		@(negedge fifo_clk);
		while (!axil_rsp.rvalid) begin
			@(negedge fifo_clk);
		end
		data = axil_rsp.rdata;
		check_axil_resp("rresp", axil_rsp.rresp, 2'b00);
		@(posedge fifo_clk);
		#1;
		axil_req.rready = 1'b0;
	endtask

	// ------------------------------------------------------------
	// Pixel source
	// ------------------------------------------------------------
	task automatic push_line();
		logic [2*PPL*8-1:0] bytes;
		int                 gap;
		for (int k = 0; k < 2 * PPL; k++) begin
			bytes[k*8 +: 8] = 8'($urandom);
		end
		exp_lnum.push_back(next_lnum);
		exp_pix.push_back(bytes);
		exp_cfg.push_back(model_cfg());
		@(posedge fifo_clk);
		#1;
		for (int i = 0; i < PPL; i++) begin
			gap = int'($urandom % 3);
			if (gap != 0) begin
				pix_valid = 1'b0;
				repeat (gap) @(posedge fifo_clk);
				#1;
			end
			pix.y        = bytes[16*i +: 8];
			pix.c        = bytes[16*i + 8 +: 8];
			pix.sol      = (i == 0);
			pix.line_num = next_lnum;
			pix_valid    = 1'b1;
			// Transfer at the next edge once ready is seen
			@(negedge fifo_clk);
			while (!pix_ready) begin
				@(negedge fifo_clk);
			end
			@(posedge fifo_clk);
			#1;
		end
		pix_valid    = 1'b0;
		next_lnum    = next_lnum + 16'd1;
		lines_pushed = lines_pushed + 1;
	endtask

	task automatic wait_drained();
		while (frames_seen != lines_pushed) begin
			@(negedge fifo_clk);
		end
	endtask

	// ------------------------------------------------------------
	// GMII monitor
	// ------------------------------------------------------------
	task automatic check_frame();
		vtx_pkg::net_cfg_t  c;
		logic [15:0]        lnum;
		logic [2*PPL*8-1:0] px;
		vtx_pkg::line_hdr_t got_hdr;
		vtx_pkg::line_hdr_t exp_hdr;
		if (burst_len != FRAME_LEN) begin
			fail_run($sformatf("** Error: gmii_tx_en burst length got %h expected %h",
				burst_len, FRAME_LEN));
		end
		if (exp_lnum.size() == 0) begin
			fail_run("A frame appeared on gmii_txd with no line pushed for it");
		end
		c    = exp_cfg.pop_front();
		lnum = exp_lnum.pop_front();
		px   = exp_pix.pop_front();
		build_frame(c, lnum, px);
		exp_hdr.line_num = lnum;
		exp_hdr.rsvd     = 16'h0000;
		got_hdr.line_num = {rx_bytes[LNUM_OFS], rx_bytes[LNUM_OFS + 1]};
		got_hdr.rsvd     = 16'h0000;
		check_line_num("line_num", got_hdr, exp_hdr);
		for (int k = 0; k < FRAME_LEN; k++) begin
			check_txd($sformatf("gmii_txd byte %0d", k), rx_bytes[k], exp_frame[k]);
		end
		frames_seen = frames_seen + 1;
	endtask

	always @(negedge fifo_clk) begin
		if (!sys_rst) begin
			if (gmii_tx_en) begin
				if (!prev_en) begin
					if (frames_seen > 0 && idle_cnt < IFG) begin
						fail_run($sformatf("Only %0d idle cycles between frames", idle_cnt));
					end
					burst_len = 0;
				end
				if (burst_len < FRAME_LEN) begin
					rx_bytes[burst_len] = gmii_txd;
				end
				burst_len = burst_len + 1;
			end else begin
				if (prev_en) begin
					check_frame();
					idle_cnt = 0;
				end
				idle_cnt = idle_cnt + 1;
			end
			prev_en = gmii_tx_en;
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge fifo_clk);
		fail_run($sformatf("Timeout after %0d cycles before all lines were sent",
			WATCHDOG_CYCLES));
	end

	initial begin
		rdata_t rd;
		fifo_clk     = 1'b0;
		sys_rst      = 1'b1;
		axil_req     = '0;
		pix_valid    = 1'b0;
		pix          = '0;
		next_lnum    = 16'h0100;
		lines_pushed = 0;
		for (int i = 0; i < 8; i++) begin
			regs_model[i] = 32'd0;
		end
		void'($urandom(32'h232d));
		repeat (5) @(posedge fifo_clk);
		#1;
		sys_rst = 1'b0;
		@(negedge fifo_clk);
		if (!pix_ready || gmii_tx_en || axil_rsp.bvalid || axil_rsp.rvalid
				|| axil_rsp.awready || axil_rsp.wready || axil_rsp.arready) begin
			fail_run("Outputs are not in their reset state after sys_rst");
		end

		// Readback of all eight registers
		for (int a = 0; a < 8; a++) begin
			axil_write(8'(a * 4), $urandom, 4'hF);
			axil_read(8'(a * 4), rd);
			check_axil_rdata($sformatf("rdata at %02h", a * 4), rd, regs_model[a]);
		end
		axil_write(vtx_pkg::REG_SRC_IP, $urandom, 4'b0101);
		axil_read(vtx_pkg::REG_SRC_IP, rd);
		check_axil_rdata("rdata after partial write", rd, regs_model[4]);
		axil_write(8'h24, $urandom, 4'hF);
		axil_read(8'h24, rd);
		check_axil_rdata("rdata at unmapped 24", rd, 32'd0);
		axil_write(vtx_pkg::REG_CTRL, 32'd0, 4'hF);

		// Disabled: fill the FIFO, expect no frame and a held stall
		fork
			begin
				repeat (4) push_line();
			end
			begin
				@(negedge fifo_clk);
				while (!(pix_valid && !pix_ready)) begin
					@(negedge fifo_clk);
				end
				repeat (200) begin
					@(negedge fifo_clk);
					if (gmii_tx_en) begin
						fail_run("A frame was sent while enable was 0");
					end
					if (pix_ready) begin
						fail_run("pix_ready rose while the FIFO was full and enable was 0");
					end
				end
				axil_write(vtx_pkg::REG_CTRL, 32'd1, 4'hF);
			end
		join

		// New addresses and ports while the first line of each group is on the wire
		for (int g = 0; g < 4; g++) begin
			wait_drained();
			push_line();
			@(negedge fifo_clk);
			while (!gmii_tx_en) begin
				@(negedge fifo_clk);
			end
			for (int a = 0; a < 7; a++) begin
				axil_write(8'(a * 4), $urandom, 4'hF);
			end
			repeat (4) push_line();
		end
		wait_drained();
		repeat (IFG + 4) @(negedge fifo_clk);

		if (frames_seen != N_LINES || exp_lnum.size() != 0) begin
			fail_run($sformatf("Saw %0d frames for %0d pushed lines", frames_seen, N_LINES));
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

// ==== vlog.f ====
+incdir+testbench
common/vtx_pkg.sv
hdl/line_packer.sv
hdl/pixel_fifo.sv
hdl/net_cfg_regs.sv
gmii_tx/crc32_gen.sv
gmii_tx/frame_builder.sv
hdl/video_udp_tx_top.sv
testbench/tb_video_udp_tx.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run the testbench
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_video_udp_tx -f vlog.f

# A failing run stops on $fatal; the verdict comes from the output
out=$(./obj_dir/Vtb_video_udp_tx 2>&1) || true
echo "$out"
echo "$out" | grep -qx '>>> PASS'
